//--- bench/fifo_assert.sv
`timescale 1ns/1ns

`include "fifo_defines.svh"

module fifo_assert
	import fifo_pkg::*;
(
	input logic   fifo,
	input logic   rst,
	input logic   rd,
	input logic   empty,
	input logic   full,
	input logic   rd_valid,
	input level_t level,
	input cnt_t   wr_drops
);

	flags_exclusive: assert property (@(posedge fifo) disable iff (rst) !(full && empty))
		else $error("full and empty are high together");

	// A valid pulse needs an accepted read on the edge before.
	valid_needs_read: assert property (@(posedge fifo) disable iff (rst)
		(!rd || empty) |=> !rd_valid)
		else $error("rd_valid rose without an accepted read");

	level_in_range: assert property (@(posedge fifo) disable iff (rst)
		level <= level_t'(1 << `FIFO_ADDR_WIDTH))
		else $error("level is above the buffer depth");

	drops_monotonic: assert property (@(posedge fifo) disable iff (rst)
		!$past(rst) |-> (wr_drops >= $past(wr_drops)))
		else $error("wr_drops decreased outside of reset");

endmodule

bind fifo_top fifo_assert assert_i (
	.fifo     (fifo),
	.rst      (rst),
	.rd       (rd),
	.empty    (empty),
	.full     (full),
	.rd_valid (rd_valid),
	.level    (level),
	.wr_drops (wr_drops)
);

//--- bench/fifo_tb.sv
`timescale 1ns/1ns

`include "fifo_defines.svh"

module fifo_tb
	import fifo_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int PHASE_CYCLES = 400;
	localparam int SEED         = 96975;
	localparam int DEPTH        = 1 << `FIFO_ADDR_WIDTH;
	localparam int TIMEOUT_NS   = 3 * PHASE_CYCLES * 2 * CLK_PERIOD;

	logic   fifo;
	logic   rst;
	logic   wr;
	data_t  wr_data;
	logic   rd;
	level_t almost_full_level;
	level_t almost_empty_level;
	data_t  rd_data;
	logic   rd_valid;
	logic   full;
	logic   empty;
	level_t level;
	logic   almost_full;
	logic   almost_empty;
	cnt_t   wr_drops;
	cnt_t   rd_drops;

	logic [31:0] rng;
	int          errors;
	int          cycles;

	// Reference model of the buffer contents and the two drop counters.
	data_t model_q[$];
	cnt_t  wr_drop_m;
	cnt_t  rd_drop_m;

	fifo_top fifo_top_i (
		.fifo               (fifo),
		.rst                (rst),
		.wr                 (wr),
		.wr_data            (wr_data),
		.rd                 (rd),
		.almost_full_level  (almost_full_level),
		.almost_empty_level (almost_empty_level),
		.rd_data            (rd_data),
		.rd_valid           (rd_valid),
		.full               (full),
		.empty              (empty),
		.level              (level),
		.almost_full        (almost_full),
		.almost_empty       (almost_empty),
		.wr_drops           (wr_drops),
		.rd_drops           (rd_drops)
	);

	initial begin
		fifo = 1'b0;
		forever #(CLK_PERIOD / 2) fifo = ~fifo;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h at %0t ns",
			name, expected, actual, $time);
	endtask

	task automatic check_outputs(input logic exp_valid, input data_t exp_data,
		input logic exp_af, input logic exp_ae);
		int count;
		count = model_q.size();
		cycles++;
		if (level !== level_t'(count)) begin
			report_mismatch("level", 32'(level_t'(count)), 32'(level));
		end
		if (full !== (count == DEPTH)) begin
			report_mismatch("full", 32'(count == DEPTH), 32'(full));
		end
		if (empty !== (count == 0)) begin
			report_mismatch("empty", 32'(count == 0), 32'(empty));
		end
		if (rd_valid !== exp_valid) begin
			report_mismatch("rd_valid", 32'(exp_valid), 32'(rd_valid));
		end
		if (exp_valid && rd_data !== exp_data) begin
			report_mismatch("rd_data", 32'(exp_data), 32'(rd_data));
		end
		if (almost_full !== exp_af) begin
			report_mismatch("almost_full", 32'(exp_af), 32'(almost_full));
		end
		if (almost_empty !== exp_ae) begin
			report_mismatch("almost_empty", 32'(exp_ae), 32'(almost_empty));
		end
		if (wr_drops !== wr_drop_m) begin
			report_mismatch("wr_drops", 32'(wr_drop_m), 32'(wr_drops));
		end
		if (rd_drops !== rd_drop_m) begin
			report_mismatch("rd_drops", 32'(rd_drop_m), 32'(rd_drops));
		end
	endtask

	// Called just after an edge. Drives one cycle, predicts the next edge and checks it.
	task automatic run_cycle(input logic w, input data_t d, input logic r);
		logic  acc_w;
		logic  acc_r;
		logic  exp_af;
		logic  exp_ae;
		data_t exp_data;
		int    count;
		count = model_q.size();
		wr = w;
		wr_data = d;
		rd = r;
		acc_w = w && (count < DEPTH);
		acc_r = r && (count > 0);
		exp_af = (count >= int'(almost_full_level)); // Flags see the level before the edge.
		exp_ae = (count <= int'(almost_empty_level));
		exp_data = '0;
		if (w && !acc_w && wr_drop_m != '1) begin
			wr_drop_m = wr_drop_m + cnt_t'(1);
		end
		if (r && !acc_r && rd_drop_m != '1) begin
			rd_drop_m = rd_drop_m + cnt_t'(1);
		end
		if (acc_r) begin
			exp_data = model_q.pop_front();
		end
		if (acc_w) begin
			model_q.push_back(d);
		end
		@(posedge fifo);
		#10;
		check_outputs(acc_r, exp_data, exp_af, exp_ae);
	endtask

	// Strobe weights are out of sixteen.
	task automatic run_phase(input int wr_weight, input int rd_weight);
		logic  w;
		logic  r;
		data_t d;
		for (int i = 0; i < PHASE_CYCLES; i++) begin
			w = (next_rand() % 16) < wr_weight;
			r = (next_rand() % 16) < rd_weight;
			d = data_t'(next_rand());
			run_cycle(w, d, r);
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all test phases finished.");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rst = 1'b1;
		wr = 1'b0;
		rd = 1'b0;
		wr_data = '0;
		almost_full_level = level_t'(12);
		almost_empty_level = level_t'(3);
		rng = SEED;
		errors = 0;
		cycles = 0;
		wr_drop_m = '0;
		rd_drop_m = '0;
		repeat (2) @(posedge fifo);
		#10;
		rst = 1'b0;
		run_cycle(1'b0, '0, 1'b0); // Outputs must show the reset state here.
		run_phase(14, 3);
		run_phase(3, 14);
		almost_full_level = level_t'(next_rand() % 17);
		almost_empty_level = level_t'(next_rand() % 17);
		run_phase(8, 8);
		$display("Cycles checked: %0d, errors: %0d", cycles, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+src
src/fifo_pkg.sv
src/fifo_mem.sv
src/fifo_ptr.sv
src/fifo_wr_guard.sv
src/fifo_rd_stage.sv
src/fifo_watermark.sv
src/fifo_top.sv
bench/fifo_assert.sv
bench/fifo_tb.sv

//--- run.sh
#!/bin/sh
# Builds the FIFO testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--top-module fifo_tb \
	-f compile.f \
	--Mdir "$BUILD_DIR" \
	-o fifo_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

"./$BUILD_DIR/fifo_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q -F '*** TEST PASSED ***' "$LOG"; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed, see $LOG."
	exit 1
fi

//--- src/fifo_defines.svh
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// Address bits of the storage array.
// Four bits give a depth of sixteen entries.
`define FIFO_ADDR_WIDTH 4

// Width of one payload word.
`define FIFO_DATA_WIDTH 16

// Width of the refused-write and refused-read counters.
// Both counters stop at their maximum value.
`define FIFO_CNT_WIDTH 8

`endif

//--- src/fifo_mem.sv
`timescale 1ns/1ns

`include "fifo_defines.svh"

module fifo_mem
	import fifo_pkg::*;
(
	input  logic  fifo,
	input  logic  wr_en,
	input  addr_t wr_addr,
	input  data_t wr_data,
	input  logic  rd_en,
	input  addr_t rd_addr,
	output data_t rd_data
);

	data_t mem [0:(1 << `FIFO_ADDR_WIDTH)-1];

	// The array starts out cleared.
	initial begin
		for (int i = 0; i < (1 << `FIFO_ADDR_WIDTH); i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge fifo) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data; // Word is stored at the accepting edge.
		end
	end

	// The read port is registered and holds its output between reads.
	always_ff @(posedge fifo) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- src/fifo_pkg.sv
`include "fifo_defines.svh"

package fifo_pkg;

	// One payload word as it moves through the buffer.
	typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

	// Index into the storage array.
	typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

	// Fill level and pointer counters.
	// The extra top bit tells a full buffer apart from an empty one.
	typedef logic [`FIFO_ADDR_WIDTH:0] level_t;

	// Saturating event counter for refused strobes.
	typedef logic [`FIFO_CNT_WIDTH-1:0] cnt_t;

endpackage

//--- src/fifo_ptr.sv
`timescale 1ns/1ns

`include "fifo_defines.svh"

module fifo_ptr
	import fifo_pkg::*;
(
	input  logic   fifo,
	input  logic   rst,
	input  logic   wr_en,
	input  logic   rd_en,
	output addr_t  wr_addr,
	output addr_t  rd_addr,
	output level_t level,
	output logic   full,
	output logic   empty
);

	level_t wr_cnt;
	level_t rd_cnt;

	// Both counters run one bit wider than the address.
	// Their difference then covers the range from zero to the full depth.
	always_ff @(posedge fifo) begin
		if (rst) begin
			wr_cnt <= '0;
		end else if (wr_en) begin
			wr_cnt <= wr_cnt + level_t'(1);
		end
	end

	always_ff @(posedge fifo) begin
		if (rst) begin
			rd_cnt <= '0;
		end else if (rd_en) begin
			rd_cnt <= rd_cnt + level_t'(1);
		end
	end

	assign wr_addr = wr_cnt[`FIFO_ADDR_WIDTH-1:0];
	assign rd_addr = rd_cnt[`FIFO_ADDR_WIDTH-1:0];

	// Level and flags follow the counters directly, with no extra register.
	assign level = wr_cnt - rd_cnt;
	assign empty = (level == '0);
	assign full  = level[`FIFO_ADDR_WIDTH]; // Only a count equal to the depth sets this bit.

endmodule

//--- src/fifo_rd_stage.sv
`timescale 1ns/1ns

module fifo_rd_stage
	import fifo_pkg::*;
(
	input  logic fifo,
	input  logic rst,
	input  logic rd,
	input  logic empty,
	output logic rd_en,
	output logic rd_valid,
	output cnt_t rd_drops
);

	logic refused;
	logic at_max;

	assign rd_en   = rd && !empty;
	assign refused = rd && empty; // Reading an empty buffer returns nothing.

	assign at_max = (rd_drops == '1);

	// The memory loads its read register on the same edge.
	// So the valid pulse lines up with the new read data.
	always_ff @(posedge fifo) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	always_ff @(posedge fifo) begin
		if (rst) begin
			rd_drops <= '0;
		end else if (refused && !at_max) begin
			rd_drops <= rd_drops + cnt_t'(1); // Saturates at the top value.
		end
	end

endmodule

//--- src/fifo_top.sv
`timescale 1ns/1ns

module fifo_top
	import fifo_pkg::*;
(
	input  logic   fifo,
	input  logic   rst,
	input  logic   wr,
	input  data_t  wr_data,
	input  logic   rd,
	input  level_t almost_full_level,
	input  level_t almost_empty_level,
	output data_t  rd_data,
	output logic   rd_valid,
	output logic   full,
	output logic   empty,
	output level_t level,
	output logic   almost_full,
	output logic   almost_empty,
	output cnt_t   wr_drops,
	output cnt_t   rd_drops
);

	logic  wr_en;
	logic  rd_en;
	data_t mem_data;
	addr_t wr_addr;
	addr_t rd_addr;

	// Only the guard and the read stage look at the flags.
	fifo_wr_guard wr_guard_i (
		.fifo     (fifo),
		.rst      (rst),
		.wr       (wr),
		.wr_data  (wr_data),
		.full     (full),
		.wr_en    (wr_en),
		.mem_data (mem_data),
		.wr_drops (wr_drops)
	);

	fifo_rd_stage rd_stage_i (
		.fifo     (fifo),
		.rst      (rst),
		.rd       (rd),
		.empty    (empty),
		.rd_en    (rd_en),
		.rd_valid (rd_valid),
		.rd_drops (rd_drops)
	);

	fifo_ptr ptr_i (
		.fifo    (fifo),
		.rst     (rst),
		.wr_en   (wr_en),
		.rd_en   (rd_en),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.level   (level),
		.full    (full),
		.empty   (empty)
	);

	fifo_mem mem_i (
		.fifo    (fifo),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (mem_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	fifo_watermark watermark_i (
		.fifo               (fifo),
		.rst                (rst),
		.level              (level),
		.almost_full_level  (almost_full_level),
		.almost_empty_level (almost_empty_level),
		.almost_full        (almost_full),
		.almost_empty       (almost_empty)
	);

endmodule

//--- src/fifo_watermark.sv
`timescale 1ns/1ns

module fifo_watermark
	import fifo_pkg::*;
(
	input  logic   fifo,
	input  logic   rst,
	input  level_t level,
	input  level_t almost_full_level,
	input  level_t almost_empty_level,
	output logic   almost_full,
	output logic   almost_empty
);

	logic above_full_mark;
	logic below_empty_mark;

	// Both thresholds are inclusive.
	assign above_full_mark  = (level >= almost_full_level);
	assign below_empty_mark = (level <= almost_empty_level);

	// Flags trail the level by one cycle.
	always_ff @(posedge fifo) begin
		if (rst) begin
			almost_full  <= 1'b0;
			almost_empty <= 1'b1; // An empty buffer sits at or below any threshold.
		end else begin
			almost_full  <= above_full_mark;
			almost_empty <= below_empty_mark;
		end
	end

endmodule

//--- src/fifo_wr_guard.sv
`timescale 1ns/1ns

module fifo_wr_guard
	import fifo_pkg::*;
(
	input  logic  fifo,
	input  logic  rst,
	input  logic  wr,
	input  data_t wr_data,
	input  logic  full,
	output logic  wr_en,
	output data_t mem_data,
	output cnt_t  wr_drops
);

	logic refused;
	logic at_max;

	// A write that meets a full buffer is lost.
	assign wr_en   = wr && !full;
	assign refused = wr && full;

	assign mem_data = wr_data;

	assign at_max = (wr_drops == '1);

	// Counts lost writes and sticks at its maximum value.
	always_ff @(posedge fifo) begin
		if (rst) begin
			wr_drops <= '0;
		end else if (refused && !at_max) begin
			wr_drops <= wr_drops + cnt_t'(1);
		end
	end

endmodule
